// ==== build.f ====
design/feeder_pkg.sv
design/feeder_ram_if.sv
design/feeder_dp_ram.sv
design/row_writer.sv
design/window_reader.sv
design/feeder_top.sv
verification/feeder_chk.sv
verification/feeder_tb.sv

// ==== design/feeder_dp_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module feeder_dp_ram import feeder_pkg::*; (
	input logic       clk,
	feeder_ram_if.ram ram
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

	// write port
	always_ff @(posedge clk) begin
		if (ram.wr_en) begin
			mem[ram.wr_addr.flat] <= ram.wr_data;
		end
	end

	// read port, registered every cycle
	always_ff @(posedge clk) begin
		ram.rd_data <= mem[ram.rd_addr.flat];
	end

endmodule

`default_nettype wire

// ==== design/feeder_pkg.sv ====
`default_nettype none

package feeder_pkg;

	localparam int DATA_W    = 16;
	localparam int NUM_SLOTS = 4;              // row slots in the line buffer
	localparam int SLOT_W    = 2;
	localparam int POS_W     = 8;              // 256 words per slot
	localparam int ADDR_W    = SLOT_W + POS_W;
	localparam int DIM_W     = 8;
	localparam int CHAN_W    = 4;
	localparam int KERNEL    = 3;
	localparam int CNT_W     = 3;              // complete rows, 0 to 4

	localparam logic [1:0] K_LAST = 2'(KERNEL - 1);

	// writer fsm codes
	localparam logic [1:0] W_IDLE = 2'd0;      // at a row boundary
	localparam logic [1:0] W_FILL = 2'd1;      // row partly written
	localparam logic [1:0] W_FULL = 2'd2;

	// reader fsm codes
	localparam logic [1:0] R_IDLE  = 2'd0;
	localparam logic [1:0] R_WAIT  = 2'd1;     // waiting on complete rows
	localparam logic [1:0] R_SWEEP = 2'd2;

	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		logic [POS_W-1:0]  pos;
	} buf_field_t;

	// slot/pos view for address generation, flat view for the ram
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		buf_field_t        f;
	} buf_addr_u;

endpackage

`default_nettype wire

// ==== design/feeder_ram_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface feeder_ram_if import feeder_pkg::*; ();

	logic              wr_en;
	buf_addr_u         wr_addr;
	logic [DATA_W-1:0] wr_data;
	buf_addr_u         rd_addr;
	logic [DATA_W-1:0] rd_data;    // valid the cycle after rd_addr

	modport writer (
		output wr_en, wr_addr, wr_data
	);

	modport reader (
		output rd_addr
	);

	modport ram (
		input  wr_en, wr_addr, wr_data, rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

// ==== design/feeder_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module feeder_top import feeder_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_start,
	input  logic              i_stride2,
	input  logic [DIM_W-1:0]  i_in_cols,
	input  logic [DIM_W-1:0]  i_in_rows,
	input  logic [CHAN_W-1:0] i_chans,
	input  logic              i_valid,
	input  logic [DATA_W-1:0] i_data,
	output logic              o_ram_full,
	output logic [DATA_W-1:0] o_data,
	output logic              o_data_valid,
	output logic              o_frame_done
);

	logic [CNT_W-1:0] rows_avail;
	logic             row_release;  // one-cycle row credit return
	logic [1:0]       release_cnt;

	feeder_ram_if ram_bus ();

	row_writer i_row_writer (
		.clk           (clk),
		.rst           (rst),
		.i_valid       (i_valid),
		.i_data        (i_data),
		.i_in_cols     (i_in_cols),
		.i_chans       (i_chans),
		.i_release     (row_release),
		.i_release_cnt (release_cnt),
		.o_rows_avail  (rows_avail),
		.o_ram_full    (o_ram_full),
		.ram           (ram_bus.writer)
	);

	window_reader i_window_reader (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_stride2     (i_stride2),
		.i_in_cols     (i_in_cols),
		.i_in_rows     (i_in_rows),
		.i_chans       (i_chans),
		.i_rows_avail  (rows_avail),
		.o_release     (row_release),
		.o_release_cnt (release_cnt),
		.o_data_valid  (o_data_valid),
		.o_frame_done  (o_frame_done),
		.ram           (ram_bus.reader)
	);

	feeder_dp_ram i_feeder_dp_ram (
		.clk (clk),
		.ram (ram_bus.ram)
	);

	assign o_data = ram_bus.rd_data;

endmodule

`default_nettype wire

// ==== design/row_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module row_writer import feeder_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_valid,
	input  logic [DATA_W-1:0] i_data,
	input  logic [DIM_W-1:0]  i_in_cols,
	input  logic [CHAN_W-1:0] i_chans,
	input  logic              i_release,
	input  logic [1:0]        i_release_cnt,
	output logic [CNT_W-1:0]  o_rows_avail,
	output logic              o_ram_full,
	feeder_ram_if.writer      ram
);

	logic [1:0]              state;
	logic [1:0]              state_next;
	logic [POS_W-1:0]        wr_pos;     // word position inside the current row
	logic [SLOT_W-1:0]       tail;       // slot being filled
	logic [DIM_W+CHAN_W-1:0] row_len;
	logic                    wr_fire;
	logic                    row_end;
	logic                    row_done;
	logic [CNT_W-1:0]        rows_next;
	buf_addr_u               waddr;

	assign row_len  = i_in_cols * i_chans;
	assign wr_fire  = i_valid && (state != W_FULL); // dropped while full
	assign row_end  = ({{CHAN_W{1'b0}}, wr_pos} == row_len - 1'b1);
	assign row_done = wr_fire && row_end;
	assign o_ram_full = (state == W_FULL);

	// a completed row and a release can land on the same edge
	always_comb begin
		rows_next = o_rows_avail;
		if (row_done) begin
			rows_next = rows_next + 1'b1;
		end
		if (i_release) begin
			rows_next = rows_next - {1'b0, i_release_cnt};
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			W_IDLE, W_FILL: if (wr_fire) begin
				state_next = row_end ? W_IDLE : W_FILL;
			end
			W_FULL: if (i_release) begin
				state_next = W_IDLE;    // position is already back at zero
			end
			default: state_next = W_IDLE;
		endcase
		if (rows_next == CNT_W'(NUM_SLOTS)) begin
			state_next = W_FULL;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= W_IDLE;
			wr_pos       <= '0;
			tail         <= '0;
			o_rows_avail <= '0;
		end else begin
			state        <= state_next;
			o_rows_avail <= rows_next;
			if (wr_fire) begin
				if (row_end) begin
					wr_pos <= '0;
					tail   <= tail + 1'b1;  // wraps over the four slots
				end else begin
					wr_pos <= wr_pos + 1'b1;
				end
			end
		end
	end

	always_comb begin
		waddr.f.slot = tail;
		waddr.f.pos  = wr_pos;
	end

	assign ram.wr_en   = wr_fire;
	assign ram.wr_addr = waddr;
	assign ram.wr_data = i_data;

endmodule

`default_nettype wire

// ==== design/window_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_reader import feeder_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_start,
	input  logic              i_stride2,
	input  logic [DIM_W-1:0]  i_in_cols,
	input  logic [DIM_W-1:0]  i_in_rows,
	input  logic [CHAN_W-1:0] i_chans,
	input  logic [CNT_W-1:0]  i_rows_avail,
	output logic              o_release,
	output logic [1:0]        o_release_cnt,
	output logic              o_data_valid,
	output logic              o_frame_done,
	feeder_ram_if.reader      ram
);

	logic [1:0]              state;
	logic [DIM_W-1:0]        out_r;      // output row
	logic [DIM_W-1:0]        out_c;      // output column
	logic [1:0]              kr;
	logic [1:0]              kc;
	logic [CHAN_W-1:0]       ch;
	logic [SLOT_W-1:0]       head;       // slot of the first row still held
	logic [DIM_W-1:0]        row_last;
	logic [DIM_W-1:0]        col_last;
	logic                    rd_fire;
	logic                    ch_end;
	logic                    kc_end;
	logic                    kr_end;
	logic                    col_end;
	logic                    last_row;
	logic                    row_end;
	logic                    frame_end;
	logic [DIM_W-1:0]        in_col;
	logic [DIM_W+CHAN_W-1:0] pos_full;
	buf_addr_u               raddr;

	// output count minus one, (in - 3) / s
	assign row_last = (i_in_rows - DIM_W'(KERNEL)) >> i_stride2;
	assign col_last = (i_in_cols - DIM_W'(KERNEL)) >> i_stride2;

	assign rd_fire   = (state == R_SWEEP);   // one read per cycle while sweeping
	assign ch_end    = (ch == i_chans - 1'b1);
	assign kc_end    = ch_end && (kc == K_LAST);
	assign kr_end    = kc_end && (kr == K_LAST);
	assign col_end   = kr_end && (out_c == col_last);
	assign last_row  = (out_r == row_last);
	assign row_end   = rd_fire && col_end;
	assign frame_end = row_end && last_row;

	// stride rows are freed per output row, the whole window on the last one
	assign o_release     = row_end;
	assign o_release_cnt = last_row ? 2'(KERNEL) : {i_stride2, ~i_stride2};

	assign in_col   = (out_c << i_stride2) + {{(DIM_W-2){1'b0}}, kc};
	assign pos_full = in_col * i_chans + ch;

	always_comb begin
		raddr.f.slot = head + kr;   // head already carries r*s
		raddr.f.pos  = pos_full[POS_W-1:0];
	end

	assign ram.rd_addr = raddr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= R_IDLE;
			out_r        <= '0;
			out_c        <= '0;
			kr           <= '0;
			kc           <= '0;
			ch           <= '0;
			head         <= '0;
			o_data_valid <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_data_valid <= rd_fire;    // matches the ram read latency
			o_frame_done <= frame_end;
			if (o_release) begin
				head <= head + o_release_cnt;
			end
			case (state)
				R_IDLE: if (i_start) begin
					state <= R_WAIT;
					out_r <= '0;
					out_c <= '0;
					kr    <= '0;
					kc    <= '0;
					ch    <= '0;
				end
				R_WAIT: if (i_rows_avail >= CNT_W'(KERNEL)) begin
					state <= R_SWEEP;
				end
				R_SWEEP: begin
					if (ch_end) begin
						ch <= '0;
						kc <= kc_end ? 2'd0 : kc + 1'b1;
					end else begin
						ch <= ch + 1'b1;
					end
					if (kc_end) begin
						kr <= kr_end ? 2'd0 : kr + 1'b1;
					end
					if (kr_end) begin
						out_c <= col_end ? '0 : out_c + 1'b1;
					end
					// end of an output row, recheck rows before the next
					if (col_end) begin
						out_r <= out_r + 1'b1;
						state <= last_row ? R_IDLE : R_WAIT;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verification/feeder_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module feeder_chk import feeder_pkg::*; (
	input logic             clk,
	input logic             rst,
	input logic             i_valid,
	input logic             i_full,
	input logic [CNT_W-1:0] i_rows_avail,
	input logic             i_release,
	input logic [1:0]       i_release_cnt,
	input logic             i_data_valid
);

	int fail_count = 0;    // assertion failures so far

	// source must hold off while the buffer is full
	no_write_full: assert property (@(posedge clk) disable iff (rst)
		i_full |-> !i_valid) else begin
		$error("word offered while line buffer full");
		fail_count++;
	end

	rows_in_range: assert property (@(posedge clk) disable iff (rst)
		i_rows_avail <= CNT_W'(NUM_SLOTS)) else begin
		$error("more complete rows than slots");
		fail_count++;
	end

	// reader never frees rows it does not hold
	release_held: assert property (@(posedge clk) disable iff (rst)
		i_release |-> ({1'b0, i_release_cnt} <= i_rows_avail)) else begin
		$error("release count above rows available");
		fail_count++;
	end

	// every window read finds its rows complete
	rows_held: assert property (@(posedge clk) disable iff (rst)
		i_data_valid |-> ($past(i_rows_avail) >= CNT_W'(KERNEL))) else begin
		$error("window read before three rows were complete");
		fail_count++;
	end

endmodule

`default_nettype wire

// ==== verification/feeder_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module feeder_tb import feeder_pkg::*; ();

	// words in and out over all tests
	localparam int IN_WORDS   = 50 + 49 + 48 + 90 + 72;
	localparam int OUT_WORDS  = 162 + 81 + 144 + 144 + 216;
	localparam int MAX_CYCLES = 2 * (IN_WORDS + OUT_WORDS) + 1000;

	logic              clk = 1'b0;
	logic              rst;
	logic              i_start;
	logic              i_stride2;
	logic [DIM_W-1:0]  i_in_cols;
	logic [DIM_W-1:0]  i_in_rows;
	logic [CHAN_W-1:0] i_chans;
	logic              i_valid;
	logic [DATA_W-1:0] i_data;
	logic              o_ram_full;
	logic [DATA_W-1:0] o_data;
	logic              o_data_valid;
	logic              o_frame_done;

	logic [DATA_W-1:0] pix [0:15][0:15][0:15];  // model image, [row][col][ch]
	integer seed = 32'h1555;
	int     cols, rows, chans, s;
	int     error_count = 0;
	int     check_count = 0;
	int     test_count = 0;
	int     first_error;
	int     valid_count = 0;
	int     done_count = 0;
	int     cycle_count = 0;
	int     chk_fails;
	string  cur_test;

	feeder_top i_feeder_top (
		.clk          (clk),
		.rst          (rst),
		.i_start      (i_start),
		.i_stride2    (i_stride2),
		.i_in_cols    (i_in_cols),
		.i_in_rows    (i_in_rows),
		.i_chans      (i_chans),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.o_ram_full   (o_ram_full),
		.o_data       (o_data),
		.o_data_valid (o_data_valid),
		.o_frame_done (o_frame_done)
	);

	bind row_writer feeder_chk i_writer_chk (
		.clk (clk), .rst (rst), .i_valid (i_valid), .i_full (o_ram_full),
		.i_rows_avail (o_rows_avail), .i_release (i_release),
		.i_release_cnt (i_release_cnt), .i_data_valid (1'b0)
	);

	bind window_reader feeder_chk i_reader_chk (
		.clk (clk), .rst (rst), .i_valid (1'b0), .i_full (1'b0),
		.i_rows_avail (i_rows_avail), .i_release (o_release),
		.i_release_cnt (o_release_cnt), .i_data_valid (o_data_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (o_data_valid) valid_count++;
		if (o_frame_done) done_count++;
	end

	task automatic compare(input string what, input logic [31:0] expv, input logic [31:0] actv);
		check_count++;
		if (expv !== actv) begin
			error_count++;
			$display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, expv, actv);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		first_error = error_count;
	endtask

	task automatic end_test();
		test_count++;
		$display("test %s finished, %0d errors", cur_test, error_count - first_error);
	endtask

	// new geometry and a fresh random image for it
	task automatic set_frame(input int n_cols, input int n_rows, input int n_chans, input int n_s);
		@(negedge clk);
		cols      = n_cols;
		rows      = n_rows;
		chans     = n_chans;
		s         = n_s;
		i_in_cols = DIM_W'(n_cols);
		i_in_rows = DIM_W'(n_rows);
		i_chans   = CHAN_W'(n_chans);
		i_stride2 = (n_s == 2);
		for (int r = 0; r < rows; r++)
			for (int c = 0; c < cols; c++)
				for (int ch = 0; ch < chans; ch++)
					pix[r][c][ch] = DATA_W'($random(seed));
	endtask

	task automatic feed_rows(input int first, input int last);
		for (int r = first; r <= last; r++) begin
			for (int c = 0; c < cols; c++) begin
				for (int ch = 0; ch < chans; ch++) begin
					@(negedge clk);
					while (o_ram_full) begin  // hold off until a row is released
						i_valid = 1'b0;
						@(negedge clk);
					end
					i_valid = 1'b1;
					i_data  = pix[r][c][ch];
				end
			end
		end
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	function automatic int words_out();
		return ((rows - KERNEL) / s + 1) * ((cols - KERNEL) / s + 1) * KERNEL * KERNEL * chans;
	endfunction

	// window order: out row, out col, kernel row, kernel col, channel
	task automatic collect_frame();
		int n;
		n = 0;
		for (int r = 0; r <= (rows - KERNEL) / s; r++)
			for (int c = 0; c <= (cols - KERNEL) / s; c++)
				for (int kr = 0; kr < KERNEL; kr++)
					for (int kc = 0; kc < KERNEL; kc++)
						for (int ch = 0; ch < chans; ch++) begin
							@(negedge clk);
							while (!o_data_valid) begin
								@(negedge clk);
							end
							n++;
							compare("data", pix[r*s+kr][c*s+kc][ch], o_data);
							compare("frame_done", n == words_out(), o_frame_done);
						end
	endtask

	task automatic run_frame(input int first_row);
		int valid_start;
		int done_start;
		valid_start = valid_count;
		done_start  = done_count;
		@(negedge clk);
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		fork
			feed_rows(first_row, rows - 1);
			collect_frame();
		join
		repeat (2) @(negedge clk);
		compare("word count", words_out(), valid_count - valid_start);
		compare("frame_done count", 1, done_count - done_start);
	endtask

	initial begin
		rst       = 1'b1;
		i_start   = 1'b0;
		i_stride2 = 1'b0;
		i_in_cols = '0;
		i_in_rows = '0;
		i_chans   = '0;
		i_valid   = 1'b0;
		i_data    = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		begin_test("reset");
		compare("ram_full", 0, o_ram_full);
		compare("data_valid", 0, o_data_valid);
		compare("frame_done", 0, o_frame_done);
		end_test();

		begin_test("stride1_5x5x2");
		set_frame(5, 5, 2, 1);
		run_frame(0);
		end_test();

		begin_test("stride2_7x7x1");
		set_frame(7, 7, 1, 2);
		run_frame(0);
		end_test();

		begin_test("full_backpressure");
		set_frame(4, 6, 2, 1);
		feed_rows(0, 3);
		compare("ram_full", 1, o_ram_full);
		run_frame(4);
		end_test();

		begin_test("two_frames");
		set_frame(9, 5, 2, 2);
		run_frame(0);
		set_frame(6, 4, 3, 1);
		run_frame(0);
		end_test();

		// bound checkers count their own assertion failures
		chk_fails = i_feeder_top.i_row_writer.i_writer_chk.fail_count
			+ i_feeder_top.i_window_reader.i_reader_chk.fail_count;
		if (chk_fails != 0) begin
			$display("assertions failed %0d times during the run", chk_fails);
			error_count += chk_fails;
		end

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
